// File: filelist.f
+incdir+bench
hw/mem_pkg.sv
hw/ex_queue.sv
hw/dcache.sv
hw/csr_file.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_top.sv
bench/mem_asserts.sv
bench/mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory-stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -f filelist.f --top-module mem_tb \
    -Mdir obj_dir -o mem_tb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/mem_tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "test failed" "$SIM_LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi
if ! grep -q "test passed" "$SIM_LOG"; then
    echo "simulation log has no pass line"
    exit 1
fi
exit 0

// File: bench/mem_ref.svh
`ifndef MEM_REF_SVH
`define MEM_REF_SVH

// Model state, updated in input order.
logic [31:0] ref_mem [MEM_WORDS];
logic [31:0] ref_csr [CSR_COUNT];
logic [31:0] ref_tid;

function automatic void ref_reset();
    for (int i = 0; i < MEM_WORDS; i++) begin
        ref_mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hc3a5_5a3c;
    end
    for (int i = 0; i < CSR_COUNT; i++) begin
        ref_csr[i] = '0;
    end
    ref_tid = '0;
endfunction

function automatic logic [31:0] ref_csr_read(input logic [13:0] a);
    if (a == CSR_TID_ADDR) begin
        return ref_tid;
    end else if (a < 14'(CSR_COUNT)) begin
        return ref_csr[a[2:0]];
    end else begin
        return '0;  // Unmapped.
    end
endfunction

function automatic void ref_csr_write(input logic [13:0] a, input logic [31:0] d);
    if (a == CSR_TID_ADDR) begin
        ref_tid = d;
    end else if (a < 14'(CSR_COUNT)) begin
        ref_csr[a[2:0]] = d;
    end
endfunction

// Byte lanes counted from the low end of the word.
function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] w,
                                         input logic [1:0] off);
    logic [31:0] sh;
    sh = w >> (8 * off);
    case (op)
        OP_LDB:  return {{24{sh[7]}}, sh[7:0]};
        OP_LDBU: return {24'h0, sh[7:0]};
        OP_LDH:  return off[0] ? 32'h0 : {{16{sh[15]}}, sh[15:0]};
        OP_LDHU: return off[0] ? 32'h0 : {16'h0, sh[15:0]};
        default: return w;
    endcase
endfunction

function automatic mem_wb_t ref_apply(input ex_mem_t op);
    mem_wb_t     e;
    logic [5:0]  idx;
    logic [31:0] old;
    idx                  = op.addr.bytes.word[5:0];  // Word index, wraps at 256 bytes.
    e.write_en           = op.reg_write_en;
    e.write_addr         = op.reg_write_addr;
    e.write_data         = op.reg_write_data;
    e.csr_write.write_en = op.csr_write_en;
    e.csr_write.addr     = op.csr_addr;
    e.csr_write.data     = op.csr_write_data;
    case (op.op)
        OP_LDB, OP_LDBU, OP_LDH, OP_LDHU, OP_LDW: begin
            e.write_data = ref_load(op.op, ref_mem[idx], op.addr.bytes.offset);
        end
        OP_STW: begin
            ref_mem[idx] = op.reg_write_data;
        end
        OP_CSRRD, OP_CSRWR, OP_CSRXCHG: begin
            old          = ref_csr_read(op.csr_addr);
            e.write_data = old;
            if (op.op == OP_CSRXCHG) begin
                e.csr_write.data = (op.csr_write_data & op.csr_mask) | (old & ~op.csr_mask);
            end
            if (op.csr_write_en) begin
                ref_csr_write(op.csr_addr, e.csr_write.data);
            end
        end
        OP_RDCNTID: begin
            e.write_data = ref_csr_read(CSR_TID_ADDR);
        end
        default: begin
        end
    endcase
    return e;
endfunction

`endif

// File: bench/mem_tb.sv
`timescale 1ns/1ps

module mem_tb;
    import mem_pkg::*;

    localparam int NUM_OPS         = 600;
    localparam int RESET_CYCLES    = 8;
    localparam int CLK_PERIOD      = 4;
    localparam int WATCHDOG_CYCLES = NUM_OPS * (MISS_CYCLES + 2) + RESET_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        ex_valid;
    ex_mem_t     ex_op;
    logic        credit;
    logic        wb_valid;
    mem_wb_t     wb_result;

    integer      seed;
    int          credits;       // Producer's view of free queue entries.
    int          sent;
    int          results_seen;
    mem_wb_t     exp_q [$];
    mem_op_e     op_q [$];
    logic [7:0]  last_store_addr;
    logic [31:0] last_lo;
    logic        have_lo;

    `include "mem_ref.svh"

    mem_top uut (
        .clk(clk), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_op(ex_op), .credit(credit),
        .wb_valid(wb_valid), .wb_result(wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
        end
    endtask

    function automatic logic [13:0] pick_csr_addr(input logic [3:0] s, input logic read_only);
        if (s < 4'd12) begin
            return {11'b0, s[2:0]};  // Low CSRs more often, for back-to-back hazards.
        end else if (s == 4'd15 && read_only) begin
            return 14'h023;
        end else begin
            return CSR_TID_ADDR;
        end
    endfunction

    function automatic ex_mem_t random_op();
        ex_mem_t     op;
        logic [31:0] r;
        logic [7:0]  byte_addr;
        op = '0;
        r  = $random(seed);
        case (r[3:0])
            4'd0:        op.op = OP_ALU;
            4'd1:        op.op = OP_LDB;
            4'd2:        op.op = OP_LDBU;
            4'd3:        op.op = OP_LDH;
            4'd4:        op.op = OP_LDHU;
            4'd5, 4'd6:  op.op = OP_LDW;
            4'd7, 4'd8:  op.op = OP_STW;
            4'd9:        op.op = OP_CSRRD;
            4'd10:       op.op = OP_CSRWR;
            4'd11, 4'd12: op.op = OP_CSRXCHG;
            4'd13:       op.op = OP_RDCNTID;
            4'd14:       op.op = OP_RDCNTVLW;
            default:     op.op = OP_RDCNTVHW;
        endcase
        // Loads go back to the last store address now and then.
        if (op.op != OP_STW && r[5:4] == 2'b00) begin
            byte_addr = last_store_addr;
        end else begin
            byte_addr = r[15:8];
        end
        op.addr           = {24'h0, byte_addr};
        op.reg_write_en   = (op.op != OP_STW);
        op.reg_write_addr = r[20:16];
        op.reg_write_data = $random(seed);
        op.csr_read_en    = op.op inside {OP_CSRRD, OP_CSRWR, OP_CSRXCHG};
        op.csr_write_en   = op.op inside {OP_CSRWR, OP_CSRXCHG};
        op.csr_addr       = pick_csr_addr(r[27:24], op.op == OP_CSRRD);
        op.csr_write_data = $random(seed);
        op.csr_mask       = $random(seed);
        return op;
    endfunction

    // ------------------------------------------------------------------
    // Result checking, one entry per wb_valid cycle.
    // ------------------------------------------------------------------
    task automatic check_result();
        mem_wb_t expected;
        mem_op_e op;
        if (exp_q.size() == 0) begin
            abort_run("a result arrived with no operation outstanding");
        end else begin
            expected = exp_q.pop_front();
            op       = op_q.pop_front();
            results_seen++;
            check_value("write_en", 32'(wb_result.write_en), 32'(expected.write_en));
            check_value("write_addr", 32'(wb_result.write_addr), 32'(expected.write_addr));
            check_value("csr_write.write_en", 32'(wb_result.csr_write.write_en),
                        32'(expected.csr_write.write_en));
            check_value("csr_write.addr", 32'(wb_result.csr_write.addr),
                        32'(expected.csr_write.addr));
            check_value("csr_write.data", wb_result.csr_write.data, expected.csr_write.data);
            case (op)
                OP_RDCNTVLW: begin
                    if (have_lo && wb_result.write_data <= last_lo) begin
                        abort_run("counter low word did not increase between reads");
                    end
                    last_lo = wb_result.write_data;
                    have_lo = 1'b1;
                end
                OP_RDCNTVHW: begin
                    // The run ends long before the low word could carry.
                    check_value("write_data", wb_result.write_data, 32'h0);
                end
                default: check_value("write_data", wb_result.write_data, expected.write_data);
            endcase
        end
    endtask

    // Outputs are sampled mid-cycle.
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (credit) begin
                    credits++;
                    if (credits > QUEUE_DEPTH) begin
                        abort_run("more credits came back than operations were sent");
                    end
                end
                if (wb_valid) check_result();
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout before all results arrived");
    end

    // ------------------------------------------------------------------
    // Reset and producer.
    // ------------------------------------------------------------------
    initial begin
        logic    idle;
        ex_mem_t op;
        seed            = 32'hbfa0_4271;
        rst_n           = 1'b0;
        ex_valid        = 1'b0;
        ex_op           = '0;
        credits         = QUEUE_DEPTH;
        sent            = 0;
        results_seen    = 0;
        last_store_addr = '0;
        last_lo         = '0;
        have_lo         = 1'b0;
        ref_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (sent < NUM_OPS) begin
            @(posedge clk);
            #1;
            idle = (3'($random(seed)) == 3'd0);
            if (credits > 0 && !idle) begin
                op = random_op();
                if (op.op == OP_STW) last_store_addr = 8'(op.addr);
                exp_q.push_back(ref_apply(op));
                op_q.push_back(op.op);
                ex_op    = op;
                ex_valid = 1'b1;
                credits--;
                sent++;
            end else begin
                ex_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
        wait (results_seen == NUM_OPS);
        repeat (10) @(posedge clk);  // Room for a stray extra result.
        if (credits == QUEUE_DEPTH) begin
            $display("test passed");
            $finish;
        end else begin
            check_value("credits", 32'(credits), 32'(QUEUE_DEPTH));
        end
    end

endmodule

// File: bench/mem_asserts.sv
`timescale 1ns/1ps

module mem_asserts (
    input logic clk,
    input logic rst_n,
    input logic credit,
    input logic wb_valid,
    input logic pop,
    input logic head_valid
);

    // ------------------------------------------------------------------
    // Quiet outputs while reset is held.
    // ------------------------------------------------------------------
    credit_in_reset: assert property (@(posedge clk) !rst_n |=> !credit)
        else $error("credit pulse while reset is held");

    wb_in_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid)
        else $error("wb_valid high while reset is held");

    // Queue handshake.
    pop_needs_head: assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_valid)
        else $error("pop with head_valid low");

endmodule

bind mem_top mem_asserts u_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .credit(credit),
    .wb_valid(wb_valid),
    .pop(pop),
    .head_valid(head_valid)
);

// File: hw/mem_top.sv
`timescale 1ns/1ps

module mem_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ex_valid,
    input  mem_pkg::ex_mem_t ex_op,
    output logic             credit,
    output logic             wb_valid,
    output mem_pkg::mem_wb_t wb_result
);
    import mem_pkg::*;

    logic        head_valid;
    ex_mem_t     head_op;
    logic        pop;
    logic        req_valid;
    logic        req_write;
    mem_addr_u   req_addr;
    logic [31:0] req_wdata;
    logic        cache_hit;
    logic [31:0] cache_rdata;
    logic        csr_read_en;
    logic [13:0] csr_read_addr;
    logic [31:0] csr_read_data;
    csr_fwd_t    csr_fwd;
    logic [63:0] cnt;
    logic        mem_valid;
    mem_wb_t     mem_wb;

    ex_queue u_queue (
        .clk(clk), .rst_n(rst_n),
        .in_valid(ex_valid), .in_op(ex_op),
        .pop(pop), .head_valid(head_valid), .head_op(head_op),
        .credit(credit)
    );

    mem_stage u_mem (
        .head_valid(head_valid), .head_op(head_op), .pop(pop),
        .req_valid(req_valid), .req_write(req_write), .addr(req_addr), .wdata(req_wdata),
        .hit(cache_hit), .rdata(cache_rdata),
        .csr_read_en(csr_read_en), .csr_read_addr(csr_read_addr),
        .csr_read_data(csr_read_data), .csr_fwd(csr_fwd),
        .cnt(cnt), .out_valid(mem_valid), .mem_wb(mem_wb)
    );

    dcache u_dcache (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_write(req_write), .addr(req_addr), .wdata(req_wdata),
        .hit(cache_hit), .rdata(cache_rdata)
    );

    csr_file u_csr (
        .clk(clk), .rst_n(rst_n),
        .read_en(csr_read_en), .read_addr(csr_read_addr), .read_data(csr_read_data),
        .csr_fwd(csr_fwd), .cnt(cnt)
    );

    wb_stage u_wb (
        .clk(clk), .rst_n(rst_n),
        .in_valid(mem_valid), .mem_wb(mem_wb),
        .wb_valid(wb_valid), .wb_result(wb_result), .csr_fwd(csr_fwd)
    );

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  mem_pkg::mem_wb_t  mem_wb,
    output logic              wb_valid,
    output mem_pkg::mem_wb_t  wb_result,
    output mem_pkg::csr_fwd_t csr_fwd
);
    import mem_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_result <= mem_wb;
        end
    end

    // Commit and forward bus share one source.
    assign csr_fwd.write_en = wb_valid && wb_result.csr_write.write_en;
    assign csr_fwd.addr     = wb_result.csr_write.addr;
    assign csr_fwd.data     = wb_result.csr_write.data;

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               head_valid,
    input  mem_pkg::ex_mem_t   head_op,
    output logic               pop,

    output logic               req_valid,
    output logic               req_write,
    output mem_pkg::mem_addr_u addr,
    output logic [31:0]        wdata,
    input  logic               hit,
    input  logic [31:0]        rdata,

    output logic               csr_read_en,
    output logic [13:0]        csr_read_addr,
    input  logic [31:0]        csr_read_data,
    input  mem_pkg::csr_fwd_t  csr_fwd,

    input  logic [63:0]        cnt,

    output logic               out_valid,
    output mem_pkg::mem_wb_t   mem_wb
);
    import mem_pkg::*;

    logic        is_load;
    logic        is_store;
    logic        pause;
    logic [1:0]  offset;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        half_bad;
    logic [31:0] csr_value;

    // ------------------------------------------------------------------
    // Cache request and stall.
    // ------------------------------------------------------------------
    assign is_load  = head_op.op inside {OP_LDB, OP_LDBU, OP_LDH, OP_LDHU, OP_LDW};
    assign is_store = (head_op.op == OP_STW);

    assign req_valid = head_valid && (is_load || is_store);
    assign req_write = is_store;
    assign addr      = head_op.addr;
    assign wdata     = head_op.reg_write_data;

    assign pause     = req_valid && !hit;  // Held until the refill lands.
    assign pop       = head_valid && !pause;
    assign out_valid = pop;

    // ------------------------------------------------------------------
    // CSR read, forwarded from writeback when the address matches.
    // ------------------------------------------------------------------
    assign csr_read_en   = head_valid && (head_op.csr_read_en || head_op.op == OP_RDCNTID);
    assign csr_read_addr = (head_op.op == OP_RDCNTID) ? CSR_TID_ADDR : head_op.csr_addr;

    always_comb begin
        if (csr_read_en && csr_fwd.write_en && (csr_fwd.addr == csr_read_addr)) begin
            csr_value = csr_fwd.data;
        end else begin
            csr_value = csr_read_data;
        end
    end

    // Load alignment.
    assign offset   = head_op.addr.bytes.offset;
    assign byte_sel = rdata[{offset, 3'b000} +: 8];
    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];
    assign half_bad = offset[0];  // Misaligned halfword gives zero.

    always_comb begin
        case (head_op.op)
            OP_LDB:      mem_wb.write_data = {{24{byte_sel[7]}}, byte_sel};
            OP_LDBU:     mem_wb.write_data = {24'b0, byte_sel};
            OP_LDH: begin
                if (half_bad) begin
                    mem_wb.write_data = '0;
                end else begin
                    mem_wb.write_data = {{16{half_sel[15]}}, half_sel};
                end
            end
            OP_LDHU: begin
                if (half_bad) begin
                    mem_wb.write_data = '0;
                end else begin
                    mem_wb.write_data = {16'b0, half_sel};
                end
            end
            OP_LDW:      mem_wb.write_data = rdata;
            OP_CSRRD,
            OP_CSRWR,
            OP_CSRXCHG,
            OP_RDCNTID:  mem_wb.write_data = csr_value;  // Old value.
            OP_RDCNTVLW: mem_wb.write_data = cnt[31:0];
            OP_RDCNTVHW: mem_wb.write_data = cnt[63:32];
            default:     mem_wb.write_data = head_op.reg_write_data;
        endcase
    end

    assign mem_wb.write_en   = head_op.reg_write_en;
    assign mem_wb.write_addr = head_op.reg_write_addr;

    // CSR write; exchange replaces only the masked bits.
    assign mem_wb.csr_write.write_en = head_op.csr_write_en;
    assign mem_wb.csr_write.addr     = head_op.csr_addr;
    assign mem_wb.csr_write.data     = (head_op.op == OP_CSRXCHG) ?
        ((csr_value & ~head_op.csr_mask) | (head_op.csr_write_data & head_op.csr_mask)) :
        head_op.csr_write_data;

endmodule

// File: hw/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              read_en,
    input  logic [13:0]       read_addr,
    output logic [31:0]       read_data,
    input  mem_pkg::csr_fwd_t csr_fwd,
    output logic [63:0]       cnt
);
    import mem_pkg::*;

    logic [31:0] csr_regs [CSR_COUNT];
    logic [31:0] tid;
    logic        rd_is_reg;
    logic        wr_is_reg;

    assign rd_is_reg = (read_addr < 14'(CSR_COUNT));
    assign wr_is_reg = (csr_fwd.addr < 14'(CSR_COUNT));

    always_comb begin
        read_data = '0;  // Unmapped addresses read as zero.
        if (read_en) begin
            if (rd_is_reg) begin
                read_data = csr_regs[read_addr[CSR_IDX_BITS-1:0]];
            end else if (read_addr == CSR_TID_ADDR) begin
                read_data = tid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < CSR_COUNT; i++) begin
                csr_regs[i] <= '0;
            end
            tid <= '0;
        end else if (csr_fwd.write_en) begin
            if (wr_is_reg) begin
                csr_regs[csr_fwd.addr[CSR_IDX_BITS-1:0]] <= csr_fwd.data;
            end else if (csr_fwd.addr == CSR_TID_ADDR) begin
                tid <= csr_fwd.data;
            end
        end
    end

    // Stable counter.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 64'd1;
        end
    end

endmodule

// File: hw/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               req_write,
    input  mem_pkg::mem_addr_u addr,
    input  logic [31:0]        wdata,
    output logic               hit,
    output logic [31:0]        rdata
);
    import mem_pkg::*;

    logic [LINE_COUNT-1:0]     line_valid;
    logic [STORE_TAG_BITS-1:0] line_tag  [LINE_COUNT];
    logic [31:0]               line_data [LINE_COUNT];
    logic [31:0]               store     [MEM_WORDS];
    logic [MISS_CNT_BITS-1:0]  miss_cnt;

    logic [LINE_BITS-1:0]      idx;
    logic [STORE_TAG_BITS-1:0] tag;
    logic [MEM_IDX_BITS-1:0]   word;
    logic                      tag_match;
    logic                      fill;
    logic                      wr_hit;

    assign idx       = addr.cache.line;
    assign tag       = addr.cache.tag[STORE_TAG_BITS-1:0];
    assign word      = {tag, idx};  // Wraps at MEM_WORDS.
    assign tag_match = line_valid[idx] && (line_tag[idx] == tag);
    assign hit       = req_valid && tag_match;
    assign rdata     = line_data[idx];
    assign wr_hit    = hit && req_write;
    assign fill      = req_valid && !tag_match &&
                       (miss_cnt == MISS_CNT_BITS'(MISS_CYCLES - 1));

    // ------------------------------------------------------------------
    // Miss counter and line state.
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss_cnt   <= '0;
            line_valid <= '0;
        end else if (fill) begin
            miss_cnt        <= '0;
            line_valid[idx] <= 1'b1;
        end else if (req_valid && !tag_match) begin
            miss_cnt <= miss_cnt + 1'b1;
        end else begin
            miss_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line_tag[idx]  <= tag;
            line_data[idx] <= store[word];
        end else if (wr_hit) begin
            line_data[idx] <= wdata;
        end
    end

    // Backing store, written through on store hits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                store[i] <= init_word(i);
            end
        end else if (wr_hit) begin
            store[word] <= wdata;
        end
    end

endmodule

// File: hw/ex_queue.sv
`timescale 1ns/1ps

module ex_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  mem_pkg::ex_mem_t  in_op,
    input  logic              pop,
    output logic              head_valid,
    output mem_pkg::ex_mem_t  head_op,
    output logic              credit
);
    import mem_pkg::*;

    ex_mem_t                 entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS:0] wr_ptr;   // Extra bit tells full from empty.
    logic [QUEUE_PTR_BITS:0] rd_ptr;
    logic                    in_valid_q;
    ex_mem_t                 in_op_q;

    // Input capture; the entry lands in the buffer one edge later.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            in_op_q <= in_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid_q) wr_ptr <= wr_ptr + 1'b1;
            if (credit)     rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_q) begin
            entries[wr_ptr[QUEUE_PTR_BITS-1:0]] <= in_op_q;
        end
    end

    assign head_valid = (wr_ptr != rd_ptr);
    assign head_op    = entries[rd_ptr[QUEUE_PTR_BITS-1:0]];
    assign credit     = pop && head_valid;  // One credit per consumed entry.

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

    // ------------------------------------------------------------------
    // Geometry and timing.
    // ------------------------------------------------------------------
    localparam int QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

    localparam int LINE_BITS      = 3;
    localparam int LINE_COUNT     = 1 << LINE_BITS;
    localparam int MEM_WORDS      = 64;
    localparam int MEM_IDX_BITS   = $clog2(MEM_WORDS);
    localparam int STORE_TAG_BITS = MEM_IDX_BITS - LINE_BITS;  // Tag bits that survive the wrap.

    localparam int MISS_CYCLES    = 3;
    localparam int MISS_CNT_BITS  = $clog2(MISS_CYCLES + 1);

    localparam logic [13:0] CSR_TID_ADDR = 14'h040;
    localparam int CSR_COUNT     = 8;
    localparam int CSR_IDX_BITS  = $clog2(CSR_COUNT);

    typedef enum logic [3:0] {
        OP_ALU,
        OP_LDB,
        OP_LDBU,
        OP_LDH,
        OP_LDHU,
        OP_LDW,
        OP_STW,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_RDCNTID,
        OP_RDCNTVLW,
        OP_RDCNTVHW
    } mem_op_e;

    // ------------------------------------------------------------------
    // One address, two decodes.
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [29:0] word;
        logic [1:0]  offset;
    } byte_view_t;

    typedef struct packed {
        logic [29-LINE_BITS:0] tag;
        logic [LINE_BITS-1:0]  line;
        logic [1:0]            offset;
    } cache_view_t;

    typedef union packed {
        byte_view_t  bytes;   // Load alignment.
        cache_view_t cache;   // Cache lookup.
    } mem_addr_u;

    typedef struct packed {
        mem_op_e     op;
        mem_addr_u   addr;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic [31:0] reg_write_data;  // Store data as well.
        logic        csr_read_en;
        logic        csr_write_en;
        logic [13:0] csr_addr;
        logic [31:0] csr_write_data;
        logic [31:0] csr_mask;
    } ex_mem_t;

    typedef struct packed {
        logic        write_en;
        logic [13:0] addr;
        logic [31:0] data;
    } csr_fwd_t;

    typedef struct packed {
        logic        write_en;
        logic [4:0]  write_addr;
        logic [31:0] write_data;
        csr_fwd_t    csr_write;
    } mem_wb_t;

    // Reset contents of the backing store.
    function automatic logic [31:0] init_word(input int i);
        return (32'(i) * 32'h0101_0101) ^ 32'hc3a5_5a3c;
    endfunction

endpackage
